// File: project.f
+incdir+include
verilog/pcs_symbol_pkg.sv
verilog/rate_match_pkg.sv
verilog/rcv_skip_deleter.sv
verilog/dual_clock_fifo.sv
verilog/ref_skip_inserter.sv
verilog/pcs_rate_match.sv
tests/tb_clocks.sv
tests/pcs_rate_match_chk.sv
tests/tb_pcs_rate_match.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       ?= tb_pcs_rate_match
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_pcs_rate_match.sv
// A slow reference first forces deletions and a fast reference then forces insertions
`timescale 1ns/1ns
`default_nettype none

`include "rate_match_consts.svh"

module tb_pcs_rate_match;
    import pcs_symbol_pkg::*;

    localparam int SLOW_REF_NS   = 104;    // Buffer fills
    localparam int FAST_REF_NS   = 96;     // Buffer drains
    localparam int MIN_PULSES    = 3;
    localparam int RESET_TIMEOUT = 100;    // Receive cycles
    localparam int DEL_TIMEOUT   = 4000;   // Receive cycles
    localparam int INS_TIMEOUT   = 8000;   // Reference cycles
    localparam int SETTLE_CYCLES = 300;
    localparam int DATA_RUN      = 8;      // Data words between skips

    int          ref_period = SLOW_REF_NS;
    logic        rcv_reset;    // Receive clock
    logic        rcv_clk;      // Reset
    logic        ref_clk;
    pcs_data_t   rcv_data;
    pcs_k_t      rcv_datak;
    pcs_data_t   ref_data;
    pcs_k_t      ref_datak;
    logic        stat_rcv_del, stat_rcv_ovfl;
    logic        stat_ref_ins, stat_ref_unfl;

    int          seed = 32'hd106782e;
    logic [31:0] next_data;    // Next counting word
    int          data_run;     // Data words since the last skip
    int          run_len;      // Data words before the next skip
    int          skip_slot;
    int          del_count = 0;
    int          ins_count = 0;

    tb_clocks u_clocks (
        .ref_period(ref_period), .rcv_reset(rcv_reset),
        .ref_clk(ref_clk), .rcv_clk(rcv_clk)
    );

    pcs_rate_match UUT (
        .rcv_reset(rcv_reset), .rcv_clk(rcv_clk), .ref_clk(ref_clk),
        .rcv_data(rcv_data), .rcv_datak(rcv_datak),
        .ref_data(ref_data), .ref_datak(ref_datak),
        .stat_rcv_del(stat_rcv_del), .stat_rcv_ovfl(stat_rcv_ovfl),
        .stat_ref_ins(stat_ref_ins), .stat_ref_unfl(stat_ref_unfl)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped");
    endtask

    // ----------------------------------------------------------
    // Source of counting words with a skip after every run of data

    initial begin
        rcv_data  = '0;
        rcv_datak = '0;
        next_data = '0;
        data_run  = 0;
        run_len   = DATA_RUN;
        skip_slot = 0;
        forever begin
            @(negedge rcv_reset);
            if (data_run == run_len) begin
                rcv_data  = `RM_SKIP_DATA;
                rcv_datak = `RM_SKIP_K;
                data_run  = 0;
                skip_slot = skip_slot + 1;
                run_len   = DATA_RUN;
                if (skip_slot % 8 == 7)   // Every eighth slot moves later
                    run_len = DATA_RUN + ($random(seed) & 3);
            end else begin
                rcv_data  = next_data;
                rcv_datak = '0;
                next_data = next_data + 32'd1;
                data_run  = data_run + 1;
            end
        end
    end

    // Pulse counters sample mid-cycle
    always @(negedge rcv_reset) begin
        if (stat_rcv_del)
            del_count = del_count + 1;
    end

    always @(negedge ref_clk) begin
        if (stat_ref_ins)
            ins_count = ins_count + 1;
    end

    // Bound checker failures end the run at once
    always @(negedge rcv_reset) begin
        if (UUT.u_chk.fail_count != 0)
            stop_with_failure("A bound assertion failed");
    end

    // ----------------------------------------------------------
    // Waits with their own limits

    task automatic await_reset_release();
        int i;
        for (i = 0; i < RESET_TIMEOUT && rcv_clk; i++)
            @(negedge rcv_reset);
        if (rcv_clk)
            stop_with_failure("Timeout: reset was never released");
    endtask

    task automatic collect_deletions();
        int i;
        for (i = 0; i < DEL_TIMEOUT && del_count < MIN_PULSES; i++)
            @(negedge rcv_reset);
        if (del_count < MIN_PULSES)
            stop_with_failure("Timeout: too few skip deletions with the slow reference clock");
    endtask

    task automatic observe_insertions();
        int i;
        for (i = 0; i < INS_TIMEOUT && ins_count < MIN_PULSES; i++)
            @(negedge ref_clk);
        if (ins_count < MIN_PULSES)
            stop_with_failure("Timeout: too few skip insertions with the fast reference clock");
    endtask

    // ----------------------------------------------------------
    // Sequence

    initial begin
        await_reset_release();

        collect_deletions();          // Reference at 104 ns

        @(negedge rcv_reset);
        ref_period = FAST_REF_NS;     // Now drain the buffer
        observe_insertions();

        repeat (SETTLE_CYCLES) @(negedge rcv_reset);

        if (UUT.u_chk.fail_count == 0 && del_count >= MIN_PULSES &&
            ins_count >= MIN_PULSES) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with_failure("Checks failed by the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: tests/pcs_rate_match_chk.sv
// Expects counting data words from the source; continuity tracking starts at the first data word out
`timescale 1ns/1ns
`default_nettype none

`include "rate_match_consts.svh"

module pcs_rate_match_chk (
    input logic                      rcv_reset,   // Receive clock
    input logic                      rcv_clk,     // Reset, active high
    input logic                      ref_clk,
    input pcs_symbol_pkg::pcs_data_t rcv_data,
    input pcs_symbol_pkg::pcs_k_t    rcv_datak,
    input pcs_symbol_pkg::pcs_data_t ref_data,
    input pcs_symbol_pkg::pcs_k_t    ref_datak,
    input logic                      rd_en,       // FIFO read side
    input logic                      rd_empty,
    input logic                      stat_rcv_del,
    input logic                      stat_rcv_ovfl,
    input logic                      stat_ref_ins,
    input logic                      stat_ref_unfl
);
    import pcs_symbol_pkg::*;

    int        fail_count = 0;
    logic      in_skip, out_skip;
    logic      loaded_q;   // Output took a word at the last edge
    logic      any_load;
    logic      out_live;   // Output holds a word from the FIFO
    logic      seen_q;     // A data word was seen on the output
    pcs_data_t exp_data;   // Next expected data word

    assign in_skip  = (rcv_data == `RM_SKIP_DATA) && (rcv_datak == `RM_SKIP_K);
    assign out_skip = (ref_data == `RM_SKIP_DATA) && (ref_datak == `RM_SKIP_K);
    assign out_live = loaded_q | any_load;

    // ----------------------------------------------------------
    // Output tracking

    always_ff @(posedge ref_clk or posedge rcv_clk) begin
        if (rcv_clk) begin
            loaded_q <= 1'b0;
            any_load <= 1'b0;
            seen_q   <= 1'b0;
            exp_data <= '0;
        end else begin
            loaded_q <= rd_en & ~rd_empty;
            if (loaded_q)
                any_load <= 1'b1;
            if (out_live && !out_skip) begin   // Every cycle, a repeated data word breaks the count
                seen_q   <= 1'b1;
                exp_data <= ref_data + pcs_data_t'(1);   // Counting source
            end
        end
    end

    // ----------------------------------------------------------
    // Reset and start-up

    a_reset_quiet: assert property (@(posedge rcv_reset)
        rcv_clk |-> !stat_rcv_del && !stat_rcv_ovfl && !stat_ref_ins && !stat_ref_unfl)
        else begin
            $error("Status output active during reset");
            fail_count = fail_count + 1;
        end

    a_reset_zero: assert property (@(posedge ref_clk)
        (!any_load && !loaded_q) |-> (ref_data == '0) && (ref_datak == '0))
        else begin
            $error("ERROR reset expected %h actual %h", 32'h0, $sampled(ref_data));
            fail_count = fail_count + 1;
        end

    // Data words step by one with skips allowed between them
    a_continuity: assert property (@(posedge ref_clk) disable iff (rcv_clk)
        (out_live && seen_q && !out_skip) |-> (ref_data == exp_data) && (ref_datak == '0))
        else begin
            $error("ERROR continuity expected %h actual %h",
                   $sampled(exp_data), $sampled(ref_data));
            fail_count = fail_count + 1;
        end

    // ----------------------------------------------------------
    // Status rules

    a_del_single: assert property (@(posedge rcv_reset) disable iff (rcv_clk)
        stat_rcv_del |=> !stat_rcv_del)
        else begin
            $error("Deletion pulse lasted more than one receive cycle");
            fail_count = fail_count + 1;
        end

    a_del_skip: assert property (@(posedge rcv_reset) disable iff (rcv_clk)
        stat_rcv_del |-> $past(in_skip, 2))   // Input two cycles back
        else begin
            $error("Deletion pulse without a skip word at the input two cycles earlier");
            fail_count = fail_count + 1;
        end

    a_ins_single: assert property (@(posedge ref_clk) disable iff (rcv_clk)
        stat_ref_ins |=> !stat_ref_ins)
        else begin
            $error("Insertion pulse lasted more than one reference cycle");
            fail_count = fail_count + 1;
        end

    a_ins_skip: assert property (@(posedge ref_clk) disable iff (rcv_clk)
        stat_ref_ins |-> $past(out_skip))
        else begin
            $error("Insertion pulse without a skip word on the output the cycle before");
            fail_count = fail_count + 1;
        end

    a_no_ovfl: assert property (@(posedge rcv_reset) disable iff (rcv_clk) !stat_rcv_ovfl)
        else begin
            $error("Write into a full buffer");
            fail_count = fail_count + 1;
        end

    a_no_unfl: assert property (@(posedge ref_clk) disable iff (rcv_clk) !stat_ref_unfl)
        else begin
            $error("Read from an empty buffer");
            fail_count = fail_count + 1;
        end

endmodule

// Attach to every DUT top instance
bind pcs_rate_match pcs_rate_match_chk u_chk (
    .rcv_reset(rcv_reset), .rcv_clk(rcv_clk), .ref_clk(ref_clk),
    .rcv_data(rcv_data), .rcv_datak(rcv_datak),
    .ref_data(ref_data), .ref_datak(ref_datak),
    .rd_en(rd_en), .rd_empty(rd_empty),
    .stat_rcv_del(stat_rcv_del), .stat_rcv_ovfl(stat_rcv_ovfl),
    .stat_ref_ins(stat_ref_ins), .stat_ref_unfl(stat_ref_unfl)
);

`default_nettype wire

// File: tests/tb_clocks.sv
// Receive clock fixed at 100 ns; reference period follows the testbench input and may change live
`timescale 1ns/1ns
`default_nettype none

module tb_clocks (
    input  int   ref_period,   // Even reference period in ns
    output logic rcv_reset,    // Receive clock
    output logic ref_clk,      // Reference clock
    output logic rcv_clk       // Reset, active high
);
    localparam int RCV_HALF   = 50;   // 100 ns period
    localparam int RST_CYCLES = 16;

    // Receive clock
    initial begin
        rcv_reset = 1'b0;
        forever #(RCV_HALF) rcv_reset = ~rcv_reset;
    end

    // Reference clock with the period read every half cycle
    initial begin
        ref_clk = 1'b0;
        forever begin
            #((ref_period > 0) ? (ref_period / 2) : RCV_HALF);   // Fallback before setup
            ref_clk = ~ref_clk;
        end
    end

    // Reset held for a fixed number of receive cycles
    initial begin
        rcv_clk = 1'b1;
        repeat (RST_CYCLES) @(posedge rcv_reset);
        @(negedge rcv_reset);
        rcv_clk = 1'b0;   // Release away from the rising edge
    end

endmodule

`default_nettype wire

// File: verilog/pcs_rate_match.sv
// Latency varies with clock phase and fill level; there is no output valid, status lines pulse
`timescale 1ns/1ns
`default_nettype none

module pcs_rate_match (
    input  logic                      rcv_reset,     // Recovered clock
    input  logic                      rcv_clk,       // Async reset, active high
    input  logic                      ref_clk,       // Reference clock
    input  pcs_symbol_pkg::pcs_data_t rcv_data,
    input  pcs_symbol_pkg::pcs_k_t    rcv_datak,
    output pcs_symbol_pkg::pcs_data_t ref_data,
    output pcs_symbol_pkg::pcs_k_t    ref_datak,
    output logic                      stat_rcv_del,  // Receive domain pulses
    output logic                      stat_rcv_ovfl,
    output logic                      stat_ref_ins,  // Reference domain pulses
    output logic                      stat_ref_unfl
);
    import pcs_symbol_pkg::*;
    import rate_match_pkg::*;

    // Receive domain
    logic        wr_en, wr_full, rcv_rst_sync;
    pcs_word_t   wr_word;
    fifo_count_t wr_count;

    // Reference domain
    logic        rd_en, rd_empty, ref_rst_sync;
    pcs_word_t   rd_word;
    fifo_count_t rd_count;

    rcv_skip_deleter u_deleter (
        .rcv_reset(rcv_reset), .rcv_clk(rcv_clk),
        .rcv_data(rcv_data), .rcv_datak(rcv_datak),
        .wr_count(wr_count), .wr_full(wr_full),
        .wr_en(wr_en), .wr_word(wr_word), .rcv_rst_sync(rcv_rst_sync),
        .stat_rcv_del(stat_rcv_del), .stat_rcv_ovfl(stat_rcv_ovfl)
    );

    dual_clock_fifo #(.word_t(pcs_word_t)) u_fifo (
        .rcv_reset(rcv_reset), .rcv_rst_sync(rcv_rst_sync),
        .wr_en(wr_en), .wr_word(wr_word), .wr_count(wr_count), .wr_full(wr_full),
        .ref_clk(ref_clk), .ref_rst_sync(ref_rst_sync),
        .rd_en(rd_en), .rd_word(rd_word), .rd_count(rd_count), .rd_empty(rd_empty)
    );

    ref_skip_inserter u_inserter (
        .ref_clk(ref_clk), .rcv_clk(rcv_clk),
        .rd_word(rd_word), .rd_count(rd_count), .rd_empty(rd_empty),
        .rd_en(rd_en), .ref_rst_sync(ref_rst_sync),
        .ref_data(ref_data), .ref_datak(ref_datak),
        .stat_ref_ins(stat_ref_ins), .stat_ref_unfl(stat_ref_unfl)
    );

endmodule

`default_nettype wire

// File: verilog/ref_skip_inserter.sv
// Output holds zero until the first read; inserts one skip per violation by holding, never stalls
`timescale 1ns/1ns
`default_nettype none

`include "rate_match_consts.svh"

module ref_skip_inserter (
    input  logic                        ref_clk,        // Reference clock
    input  logic                        rcv_clk,        // Async reset, active high
    input  pcs_symbol_pkg::pcs_word_t   rd_word,        // FIFO head word
    input  rate_match_pkg::fifo_count_t rd_count,
    input  logic                        rd_empty,
    output logic                        rd_en,
    output logic                        ref_rst_sync,   // Reset for the read domain
    output pcs_symbol_pkg::pcs_data_t   ref_data,
    output pcs_symbol_pkg::pcs_k_t      ref_datak,
    output logic                        stat_ref_ins,
    output logic                        stat_ref_unfl
);
    import pcs_symbol_pkg::*;
    import rate_match_pkg::*;

    logic        ref_rst_meta;
    pcs_word_t   out_word_q;    // Output register
    logic        out_skip_q;    // Output register holds a skip
    rd_state_t   rd_state;
    wait_count_t wait_cnt;

    // ----------------------------------------------------------
    // Reset synchronizer

    always_ff @(posedge ref_clk or posedge rcv_clk) begin
        if (rcv_clk) begin
            ref_rst_meta <= 1'b1;
            ref_rst_sync <= 1'b1;
        end else begin
            ref_rst_meta <= 1'b0;
            ref_rst_sync <= ref_rst_meta;
        end
    end

    // Read in normal and waiting; in violation skip one read on a skip
    assign rd_en = (rd_state == rd_st_normal) | (rd_state == rd_st_waiting) |
                   ((rd_state == rd_st_violation) & ~out_skip_q);

    // ----------------------------------------------------------
    // Insert machine

    always_ff @(posedge ref_clk or posedge ref_rst_sync) begin
        if (ref_rst_sync) begin
            rd_state <= rd_st_init;
            wait_cnt <= '0;
        end else begin
            wait_cnt <= '0;
            case (rd_state)
                rd_st_init:
                    if (rd_count >= fifo_count_t'(`RM_FIFO_DEPTH / 2))   // Half full
                        rd_state <= rd_st_normal;
                rd_st_normal:
                    if (rd_count < fifo_count_t'(`RM_MIN_USED))
                        rd_state <= rd_st_violation;
                rd_st_violation:
                    if (out_skip_q)          // Held this cycle so repeated once
                        rd_state <= rd_st_waiting;
                rd_st_waiting: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == wait_count_t'(`RM_WAIT_CYCLES - 1))
                        rd_state <= rd_st_normal;
                end
                default:
                    rd_state <= rd_st_init;
            endcase
        end
    end

    // ----------------------------------------------------------
    // Output register and status

    always_ff @(posedge ref_clk or posedge ref_rst_sync) begin
        if (ref_rst_sync) begin
            out_word_q    <= '0;
            out_skip_q    <= 1'b0;
            stat_ref_ins  <= 1'b0;
            stat_ref_unfl <= 1'b0;
        end else begin
            if (rd_en & ~rd_empty) begin       // Load only real words
                out_word_q <= rd_word;
                out_skip_q <= is_skip_word(rd_word);
            end
            stat_ref_ins  <= (rd_state == rd_st_violation) & out_skip_q;
            stat_ref_unfl <= rd_en & rd_empty;
        end
    end

    assign ref_data  = out_word_q.data;
    assign ref_datak = out_word_q.k;

endmodule

`default_nettype wire

// File: verilog/dual_clock_fifo.sv
// Depth must be a power of two; counts are conservative because the opposite pointer lags
`timescale 1ns/1ns
`default_nettype none

`include "rate_match_consts.svh"

module dual_clock_fifo #(
    parameter type word_t = pcs_symbol_pkg::pcs_word_t   // Any packed payload
) (
    // Write domain
    input  logic                        rcv_reset,     // Write clock
    input  logic                        rcv_rst_sync,
    input  logic                        wr_en,
    input  word_t                       wr_word,
    output rate_match_pkg::fifo_count_t wr_count,
    output logic                        wr_full,
    // Read domain
    input  logic                        ref_clk,
    input  logic                        ref_rst_sync,
    input  logic                        rd_en,
    output word_t                       rd_word,       // Show-ahead head word
    output rate_match_pkg::fifo_count_t rd_count,
    output logic                        rd_empty
);
    localparam int unsigned DEPTH  = `RM_FIFO_DEPTH;
    localparam int unsigned ADDR_W = $clog2(DEPTH);

    typedef logic [ADDR_W : 0] ptr_t;   // Extra bit tells full from empty

    word_t mem [DEPTH];

    ptr_t wr_bin, wr_gray;        // Write pointer
    ptr_t rd_bin, rd_gray;        // Read pointer
    ptr_t rd_gray_s1, rd_gray_s2; // Read pointer in write domain
    ptr_t wr_gray_s1, wr_gray_s2; // Write pointer in read domain
    ptr_t rd_bin_s, wr_bin_s;
    logic wr_do, rd_do;

    function automatic ptr_t bin_to_gray(input ptr_t b);
        return b ^ (b >> 1);
    endfunction

    function automatic ptr_t gray_to_bin(input ptr_t g);
        ptr_t b;
        b[ADDR_W] = g[ADDR_W];
        for (int i = ADDR_W - 1; i >= 0; i--) begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    // ----------------------------------------------------------
    // Write side

    assign wr_do = wr_en & ~wr_full;    // Write into full is dropped

    always_ff @(posedge rcv_reset) begin
        if (wr_do)
            mem[wr_bin[ADDR_W - 1 : 0]] <= wr_word;
    end

    always_ff @(posedge rcv_reset or posedge rcv_rst_sync) begin
        if (rcv_rst_sync) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            if (wr_do) begin
                wr_bin  <= wr_bin + 1'b1;
                wr_gray <= bin_to_gray(wr_bin + 1'b1);   // Gray is registered
            end
            rd_gray_s1 <= rd_gray;      // Two-flop crossing
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    assign rd_bin_s = gray_to_bin(rd_gray_s2);
    assign wr_count = wr_bin - rd_bin_s;
    assign wr_full  = (wr_count == ptr_t'(DEPTH));

    // ----------------------------------------------------------
    // Read side

    assign rd_do   = rd_en & ~rd_empty;  // Read from empty is dropped
    assign rd_word = mem[rd_bin[ADDR_W - 1 : 0]];

    always_ff @(posedge ref_clk or posedge ref_rst_sync) begin
        if (ref_rst_sync) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            if (rd_do) begin
                rd_bin  <= rd_bin + 1'b1;
                rd_gray <= bin_to_gray(rd_bin + 1'b1);
            end
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    assign wr_bin_s = gray_to_bin(wr_gray_s2);
    assign rd_count = wr_bin_s - rd_bin;
    assign rd_empty = (rd_count == '0);

endmodule

`default_nettype wire

// File: verilog/rcv_skip_deleter.sv
// Expects a word every receive cycle; deletes at most one skip per violation and never stalls
`timescale 1ns/1ns
`default_nettype none

`include "rate_match_consts.svh"

module rcv_skip_deleter (
    input  logic                        rcv_reset,     // Recovered clock
    input  logic                        rcv_clk,       // Async reset, active high
    input  pcs_symbol_pkg::pcs_data_t   rcv_data,
    input  pcs_symbol_pkg::pcs_k_t      rcv_datak,
    input  rate_match_pkg::fifo_count_t wr_count,      // Write side occupancy
    input  logic                        wr_full,
    output logic                        wr_en,
    output pcs_symbol_pkg::pcs_word_t   wr_word,
    output logic                        rcv_rst_sync,  // Reset for the write domain
    output logic                        stat_rcv_del,
    output logic                        stat_rcv_ovfl
);
    import pcs_symbol_pkg::*;
    import rate_match_pkg::*;

    logic        rcv_rst_meta;
    pcs_word_t   in_word;
    logic        word_vld_q;    // Input register holds a real word
    logic        skip_q;        // Registered word is a skip
    wr_state_t   wr_state;
    wait_count_t wait_cnt;

    // ----------------------------------------------------------
    // Reset synchronizer

    always_ff @(posedge rcv_reset or posedge rcv_clk) begin
        if (rcv_clk) begin
            rcv_rst_meta <= 1'b1;
            rcv_rst_sync <= 1'b1;
        end else begin
            rcv_rst_meta <= 1'b0;
            rcv_rst_sync <= rcv_rst_meta;   // Release two edges later
        end
    end

    // ----------------------------------------------------------
    // Input register and skip detect

    assign in_word = '{data: rcv_data, k: rcv_datak};

    always_ff @(posedge rcv_reset) begin
        wr_word <= in_word;   // Payload only
    end

    always_ff @(posedge rcv_reset or posedge rcv_rst_sync) begin
        if (rcv_rst_sync) begin
            word_vld_q <= 1'b0;
            skip_q     <= 1'b0;
        end else begin
            word_vld_q <= 1'b1;
            skip_q     <= is_skip_word(in_word);
        end
    end

    // Drop the registered skip while in violation
    assign wr_en = word_vld_q & ~((wr_state == wr_st_violation) & skip_q);

    // ----------------------------------------------------------
    // Delete machine

    always_ff @(posedge rcv_reset or posedge rcv_rst_sync) begin
        if (rcv_rst_sync) begin
            wr_state <= wr_st_normal;
            wait_cnt <= '0;
        end else begin
            wait_cnt <= '0;
            case (wr_state)
                wr_st_normal:
                    if (wr_count > fifo_count_t'(`RM_MAX_USED))
                        wr_state <= wr_st_violation;
                wr_st_violation:
                    if (skip_q)                   // This skip is the one dropped
                        wr_state <= wr_st_waiting;
                wr_st_waiting: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == wait_count_t'(`RM_WAIT_CYCLES - 1))
                        wr_state <= wr_st_normal;
                end
                default:
                    wr_state <= wr_st_normal;
            endcase
        end
    end

    // Status pulses
    always_ff @(posedge rcv_reset or posedge rcv_rst_sync) begin
        if (rcv_rst_sync) begin
            stat_rcv_del  <= 1'b0;
            stat_rcv_ovfl <= 1'b0;
        end else begin
            stat_rcv_del  <= word_vld_q & skip_q & (wr_state == wr_st_violation);
            stat_rcv_ovfl <= wr_en & wr_full;   // Write was ignored
        end
    end

endmodule

`default_nettype wire

// File: verilog/rate_match_pkg.sv
// Count width assumes a power-of-two depth; wait counter width assumes a power-of-two wait time
`default_nettype none

`include "rate_match_consts.svh"

package rate_match_pkg;

    // Occupancy 0 .. depth inclusive
    typedef logic [$clog2(`RM_FIFO_DEPTH + 1) - 1 : 0] fifo_count_t;

    // Wait state counter
    typedef logic [$clog2(`RM_WAIT_CYCLES) - 1 : 0] wait_count_t;

    // Receive side delete machine
    typedef enum logic [1 : 0] {
        wr_st_normal    = 2'b00,   // Writing every word
        wr_st_violation = 2'b01,   // Looking for a skip to drop
        wr_st_waiting   = 2'b10    // Let the count settle
    } wr_state_t;

    // Reference side insert machine
    typedef enum logic [1 : 0] {
        rd_st_init      = 2'b00,   // Fill to half before reading
        rd_st_normal    = 2'b01,   // Reading every cycle
        rd_st_violation = 2'b10,   // Looking for a skip to repeat
        rd_st_waiting   = 2'b11    // Let the count settle
    } rd_state_t;

endpackage

`default_nettype wire

// File: verilog/pcs_symbol_pkg.sv
// Word layout is fixed by the constants header; the skip match needs data and K flags exact
`default_nettype none

`include "rate_match_consts.svh"

package pcs_symbol_pkg;

    // ----------------------------------------------------------
    // Field types

    typedef logic [8 * `RM_BYTES - 1 : 0] pcs_data_t;  // Data bytes
    typedef logic [`RM_BYTES - 1 : 0]     pcs_k_t;     // One K flag per byte

    // Full symbol word as it travels through the buffer
    typedef struct packed {
        pcs_data_t data;   // Upper 32 bits
        pcs_k_t    k;      // Lower 4 bits
    } pcs_word_t;

    // ----------------------------------------------------------
    // Skip pattern match

    function automatic logic is_skip_word(input pcs_word_t word);
        // Both fields must match
        return (word.data == `RM_SKIP_DATA) && (word.k == `RM_SKIP_K);
    endfunction

endpackage

`default_nettype wire

// File: include/rate_match_consts.svh
// Fixed build constants; the FIFO depth must stay a power of two and MAX/MIN must fit below it
`ifndef RATE_MATCH_CONSTS_SVH
`define RATE_MATCH_CONSTS_SVH

// ----------------------------------------------------------
// Word format

`define RM_BYTES        4               // Bytes per PCS word

// Skip ordered set used for rate adjustment
`define RM_SKIP_DATA    32'h7B4A4ABC    // Data bytes of the skip word
`define RM_SKIP_K       4'h1            // K flags of the skip word

// ----------------------------------------------------------
// Elastic buffer sizing

`define RM_FIFO_DEPTH   32              // Words in the dual-clock FIFO

`define RM_MAX_USED     20              // Above this the receive side deletes a skip
`define RM_MIN_USED     10              // Below this the reference side inserts a skip

// Settle time after each adjustment
`define RM_WAIT_CYCLES  4               // Cycles in the waiting state

`endif
